// ==== rtl/noc_pkg.sv ====
package noc_pkg;

  // the router has a local port and four mesh neighbours.
  localparam int num_ports = 5;

  localparam int default_data_width = 32;
  localparam int default_fifo_depth = 4;

  // port order also sets the rotation order of the arbiter.
  typedef enum logic [2:0] {
    port_local = 3'd0,
    port_north = 3'd1,
    port_east  = 3'd2,
    port_west  = 3'd3,
    port_south = 3'd4
  } port_e;

  // one-hot states. bit p+1 marks the port p that is being served.
  typedef enum logic [5:0] {
    arb_idle  = 6'b000001,
    arb_local = 6'b000010,
    arb_north = 6'b000100,
    arb_east  = 6'b001000,
    arb_west  = 6'b010000,
    arb_south = 6'b100000
  } arb_state_e;

  function automatic arb_state_e state_of_port(input port_e p);
    return arb_state_e'(6'b000010 << p);
  endfunction

endpackage

// ==== rtl/input_fifo.sv ====
`timescale 1ns/100ps

module input_fifo #(
  parameter int data_width = noc_pkg::default_data_width,
  parameter int fifo_depth = noc_pkg::default_fifo_depth
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rts_in,
  input  logic [data_width-1:0] flit_in,
  output logic                  dcts_in,
  input  logic                  pop,
  output logic                  req,
  output logic [data_width-1:0] head
);

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  logic [data_width-1:0] mem [fifo_depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic                  push;

  // pointers wrap at the depth, which need not be a power of two.
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push    = rts_in && dcts_in;
  assign dcts_in = (count != cnt_width'(fifo_depth));
  assign req     = (count != '0);
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= flit_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the grant comes from the arbiter, which must only serve a non-empty buffer.
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> req
  );

  // occupancy never runs past the depth, so no flit is ever overwritten.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    count <= cnt_width'(fifo_depth)
  );

endmodule

// ==== rtl/output_arbiter.sv ====
`timescale 1ns/100ps

module output_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [noc_pkg::num_ports-1:0] req,
  input  logic                         dcts,
  output logic                         rts,
  output logic [noc_pkg::num_ports-1:0] grant,
  output logic [noc_pkg::num_ports-1:0] xbar_sel
);

  import noc_pkg::*;

  arb_state_e state;
  arb_state_e next_state;
  logic       next_rts;

  // sticky rotating priority. the scan starts at the port being served,
  // so a port keeps the link while it still holds flits.
  function automatic arb_state_e choose(
    input arb_state_e           cur,
    input logic [num_ports-1:0] r
  );
    int         start;
    int         idx;
    arb_state_e pick;
    start = 0;
    for (int p = 0; p < num_ports; p++) begin
      if (cur[p+1]) begin
        start = p;
      end
    end
    pick = arb_idle;
    // walk backwards so the nearest requester in rotation order wins.
    for (int i = num_ports - 1; i >= 0; i--) begin
      idx = (start + i) % num_ports;
      if (r[idx]) begin
        pick = state_of_port(port_e'(idx));
      end
    end
    return pick;
  endfunction

  always_comb begin
    next_state = state;
    next_rts   = rts;
    if (!rts) begin
      // req is only sampled here, after the previous pop has settled.
      next_state = choose(state, req);
      next_rts   = (next_state != arb_idle);
    end else if (dcts) begin
      // transfer this cycle. the state stays so the next scan starts here.
      next_rts = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= arb_idle;
      rts   <= 1'b0;
    end else begin
      state <= next_state;
      rts   <= next_rts;
    end
  end

  assign xbar_sel = state[num_ports:1];
  assign grant    = xbar_sel & {num_ports{rts && dcts}};

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  );

  // the link request and the selected flit hold until the downstream accepts.
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    rts && !dcts |=> rts && $stable(xbar_sel)
  );

  a_no_rts_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    state == arb_idle |-> !rts
  );

endmodule

// ==== rtl/xbar_column.sv ====
`timescale 1ns/100ps

module xbar_column #(
  parameter int data_width = noc_pkg::default_data_width
) (
  input  logic [noc_pkg::num_ports-1:0]                 sel,
  input  logic [noc_pkg::num_ports-1:0][data_width-1:0] head,
  output logic [data_width-1:0]                         flit
);

  import noc_pkg::*;

  // and-or mux. an empty select gives an all-zero flit.
  always_comb begin
    flit = '0;
    for (int p = 0; p < num_ports; p++) begin
      flit = flit | (head[p] & {data_width{sel[p]}});
    end
  end

  // two set bits would merge two head flits on the link.
  always_comb begin
    a_sel_onehot: assert final ($onehot0(sel));
  end

endmodule

// ==== rtl/router_out_channel.sv ====
`timescale 1ns/100ps

module router_out_channel #(
  parameter int data_width = noc_pkg::default_data_width,
  parameter int fifo_depth = noc_pkg::default_fifo_depth
) (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [noc_pkg::num_ports-1:0]                 rts_in,
  input  logic [noc_pkg::num_ports-1:0][data_width-1:0] flit_in,
  output logic [noc_pkg::num_ports-1:0]                 dcts_in,
  output logic [data_width-1:0]                         flit,
  output logic                                          rts,
  input  logic                                          dcts
);

  import noc_pkg::*;

  logic [num_ports-1:0]                 req;
  logic [num_ports-1:0]                 grant;
  logic [num_ports-1:0]                 xbar_sel;
  logic [num_ports-1:0][data_width-1:0] head;

  // one buffer per input link, indexed by port.
  for (genvar p = 0; p < num_ports; p++) begin : g_input
    input_fifo #(
      .data_width (data_width),
      .fifo_depth (fifo_depth)
    ) i_input_fifo (
      .clk     (clk),
      .rst     (rst),
      .rts_in  (rts_in[p]),
      .flit_in (flit_in[p]),
      .dcts_in (dcts_in[p]),
      .pop     (grant[p]),
      .req     (req[p]),
      .head    (head[p])
    );
  end

  output_arbiter i_output_arbiter (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .dcts     (dcts),
    .rts      (rts),
    .grant    (grant),
    .xbar_sel (xbar_sel)
  );

  xbar_column #(
    .data_width (data_width)
  ) i_xbar_column (
    .sel  (xbar_sel),
    .head (head),
    .flit (flit)
  );

endmodule

// ==== sim/tb_router_out_channel.sv ====
`timescale 1ns/100ps

module tb_router_out_channel;

  import noc_pkg::*;

  localparam int data_width     = default_data_width;
  localparam int fifo_depth     = default_fifo_depth;
  localparam int flits_per_port = 40;
  localparam int total_flits    = num_ports * flits_per_port;
  localparam int timeout_cycles = 4000;

  logic                                 clk = 1'b0;
  logic                                 rst;
  logic [num_ports-1:0]                 rts_in;
  logic [num_ports-1:0][data_width-1:0] flit_in;
  logic [num_ports-1:0]                 dcts_in;
  logic [data_width-1:0]                flit;
  logic                                 rts;
  logic                                 dcts;

  // the scoreboard is updated once per cycle at the falling edge.
  logic [data_width-1:0] pending [num_ports][$];
  int                    occ [num_ports] = '{default: 0};
  int                    sent [num_ports] = '{default: 0};
  logic                  wrote [num_ports] = '{default: 1'b0};
  int                    received = 0;
  int                    errors = 0;
  int                    timeouts = 0;
  int                    cycle_count = 0;

  // the reference arbiter keeps its last choice and the port it expects next.
  int                    last_pick = -1;
  int                    expected_port = -1;
  logic                  choice_pending = 1'b0;
  logic                  prev_transfer = 1'b0;
  logic                  prev_stall = 1'b0;
  logic [data_width-1:0] prev_flit = '0;

  router_out_channel #(
    .data_width (data_width),
    .fifo_depth (fifo_depth)
  ) i_router_out_channel (
    .clk     (clk),
    .rst     (rst),
    .rts_in  (rts_in),
    .flit_in (flit_in),
    .dcts_in (dcts_in),
    .flit    (flit),
    .rts     (rts),
    .dcts    (dcts)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [data_width-1:0] make_flit(input int p, input int seq);
    logic [data_width-1:0] f;
    f = '0;
    f[data_width-1 -: 3] = 3'(p);
    f[15:0] = 16'(seq);
    return f;
  endfunction

  // first port with buffered flits in a scan that starts at the port last served.
  function automatic int next_choice(input int last, input int count [num_ports]);
    int start;
    int idx;
    start = (last < 0) ? 0 : last;
    for (int i = 0; i < num_ports; i++) begin
      idx = (start + i) % num_ports;
      if (count[idx] > 0) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic report_mismatch(input string test, input logic [data_width-1:0] expected,
                                 input logic [data_width-1:0] actual);
    $display("Error %s: expected %0h, actual %0h", test, expected, actual);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    errors++;
  endtask

  task automatic drive_upstream();
    logic busy;
    int   weight;
    for (int p = 0; p < num_ports; p++) begin
      busy = rts_in[p];
      if (busy && wrote[p]) begin
        sent[p]++;
        busy = 1'b0;
      end
      // heavy load for the first half of each stream, sparse for the rest.
      weight = (sent[p] < flits_per_port / 2) ? 12 : 2;
      if (!busy && sent[p] < flits_per_port && $urandom_range(15) < weight) begin
        flit_in[p] = make_flit(p, sent[p]);
        busy = 1'b1;
      end
      rts_in[p] = busy;
    end
  endtask

  task automatic end_of_run();
    $display("check errors: %0d, timeouts: %0d, flits delivered: %0d of %0d",
             errors, timeouts, received, total_flits);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  always @(negedge clk) begin
    logic                  transfer;
    int                    port;
    int                    pick;
    logic [data_width-1:0] exp_flit;
    if (!rst) begin
      transfer = rts && dcts;
      if (prev_transfer) begin
        assert (!rts) else report_failure("rts stayed high in the cycle after a transfer");
      end
      if (prev_stall) begin
        assert (rts) else report_failure("rts dropped while the downstream was stalling");
        assert (flit == prev_flit) else report_mismatch("stall_hold", prev_flit, flit);
      end
      for (int p = 0; p < num_ports; p++) begin
        assert (dcts_in[p] == (occ[p] != fifo_depth))
          else report_mismatch($sformatf("input_backpressure port %0d", p),
                               occ[p] != fifo_depth, dcts_in[p]);
      end
      if (choice_pending) begin
        assert (rts == (last_pick >= 0))
          else report_mismatch("request_after_choice", last_pick >= 0, rts);
      end
      choice_pending = !rts;
      if (!rts) begin
        pick = next_choice(last_pick, occ);
        last_pick = pick;
        expected_port = pick;
      end
      if (transfer) begin
        port = int'(flit[data_width-1 -: 3]);
        assert (port == expected_port) else report_mismatch("priority", expected_port, port);
        if (port < num_ports && pending[port].size() > 0) begin
          exp_flit = pending[port].pop_front();
          assert (flit == exp_flit) else report_mismatch("delivery", exp_flit, flit);
          occ[port]--;
        end else begin
          report_failure($sformatf("flit %0h arrived with nothing pending on its port", flit));
        end
        received++;
      end
      for (int p = 0; p < num_ports; p++) begin
        wrote[p] = rts_in[p] && dcts_in[p];
        if (wrote[p]) begin
          pending[p].push_back(flit_in[p]);
          occ[p]++;
        end
      end
      prev_transfer = transfer;
      prev_stall = rts && !dcts;
      prev_flit = flit;
    end
  end

  // upstream links and the downstream model change 1 ns after each rising edge.
  initial begin
    void'($urandom(32'hd69a));
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      drive_upstream();
      dcts = ($urandom_range(3) != 0);
    end
  end

  initial begin
    wait (cycle_count >= timeout_cycles);
    $display("run timed out after %0d cycles with %0d of %0d flits delivered",
             cycle_count, received, total_flits);
    timeouts++;
    end_of_run();
  end

  initial begin
    rst = 1'b1;
    rts_in = '0;
    flit_in = '0;
    dcts = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (!rts) else report_mismatch("reset", 0, rts);
    assert (dcts_in == '1) else report_mismatch("reset", {num_ports{1'b1}}, dcts_in);
    wait (received == total_flits);
    repeat (4) @(posedge clk);
    for (int p = 0; p < num_ports; p++) begin
      assert (pending[p].size() == 0)
        else report_failure($sformatf("port %0d still has accepted flits pending", p));
    end
    end_of_run();
  end

endmodule

// ==== verilog.f ====
rtl/noc_pkg.sv
rtl/input_fifo.sv
rtl/output_arbiter.sv
rtl/xbar_column.sv
rtl/router_out_channel.sv
sim/tb_router_out_channel.sv

// ==== Bender.yml ====
package:
  name: router_out_channel

sources:
  - rtl/noc_pkg.sv
  - rtl/input_fifo.sv
  - rtl/output_arbiter.sv
  - rtl/xbar_column.sv
  - rtl/router_out_channel.sv
  - target: simulation
    files:
      - sim/tb_router_out_channel.sv
